// ==== design/gen_cfg_pkg.sv ====
/* traffic generator configuration package
   bus widths, register map, control fields and port FSM states */
`default_nettype none

package gen_cfg_pkg;

    // AXI-Lite bus geometry
    localparam int AXIL_DATA_W = 32;
    localparam int AXIL_ADDR_W = 6;
    localparam int AXIL_STRB_W = AXIL_DATA_W / 8;
    localparam int IDX_W       = AXIL_ADDR_W - 2;

    // generator field widths
    localparam int CHAN_W = 10;
    localparam int LEN_W  = 16;

    typedef logic [AXIL_DATA_W-1:0] data_t;
    typedef logic [AXIL_ADDR_W-1:0] addr_t;
    typedef logic [AXIL_STRB_W-1:0] strb_t;
    typedef logic [IDX_W-1:0]       reg_idx_t;
    typedef logic [LEN_W-1:0]       len_t;
    typedef logic [CHAN_W-1:0]      chan_t;
    typedef logic [31:0]            pause_t;
    typedef logic [31:0]            count_t;

    // word indices of the register map
    localparam reg_idx_t REG_CONTROL     = 4'd0;
    localparam reg_idx_t REG_FIXED_LEN   = 4'd1;
    localparam reg_idx_t REG_MIN_LEN     = 4'd2;
    localparam reg_idx_t REG_MAX_LEN     = 4'd3;
    localparam reg_idx_t REG_FIXED_CHAN  = 4'd4;
    localparam reg_idx_t REG_MIN_CHAN    = 4'd5;
    localparam reg_idx_t REG_MAX_CHAN    = 4'd6;
    localparam reg_idx_t REG_FIXED_PAUSE = 4'd7;
    localparam reg_idx_t REG_MIN_PAUSE   = 4'd8;
    localparam reg_idx_t REG_MAX_PAUSE   = 4'd9;
    localparam reg_idx_t REG_CNT_PACKET  = 4'd10;

    // control register bits
    localparam int CTRL_START      = 0;
    localparam int CTRL_STOP       = 1;
    localparam int CTRL_AUTO_LEN   = 2;
    localparam int CTRL_AUTO_CHAN  = 3;
    localparam int CTRL_AUTO_PAUSE = 4;
    localparam int CTRL_USE_LIMIT  = 5;

    // lengths are 16 bit wide, upper byte lanes are ignored
    localparam strb_t LEN_STRB_MASK = 4'b0011;

    localparam logic [1:0] RESP_OKAY = 2'b00;

    typedef enum logic [1:0] {W_IDLE, W_COLLECT, W_WRITE, W_RESP} wr_state_t;
    typedef enum logic [1:0] {R_IDLE, R_FETCH, R_RESP} rd_state_t;

endpackage

`default_nettype wire

// ==== design/axil_write_port.sv ====
/* AXI-Lite write channel slave
   collects address and data in any order, then issues one register write */
`timescale 1ns/1ps
`default_nettype none

module axil_write_port
    import gen_cfg_pkg::*;
(
    input  logic       clk,
    input  logic       reset_n,
    input  addr_t      awaddr_i,
    input  logic       awvalid_i,
    output logic       awready_o,
    input  data_t      wdata_i,
    input  strb_t      wstrb_i,
    input  logic       wvalid_i,
    output logic       wready_o,
    output logic [1:0] bresp_o,
    output logic       bvalid_o,
    input  logic       bready_i,
    output logic       wr_en_o,
    output reg_idx_t   wr_idx_o,
    output data_t      wr_data_o,
    output strb_t      wr_strb_o
);

    wr_state_t state_q;
    wr_state_t state_d;
    logic      aw_held_q;
    logic      w_held_q;
    logic      accepting;
    logic      aw_hs;
    logic      w_hs;
    logic      aw_have;
    logic      w_have;

    // each channel is ready only until its beat is held
    assign accepting = (state_q == W_IDLE) || (state_q == W_COLLECT);
    assign awready_o = accepting && !aw_held_q;
    assign wready_o  = accepting && !w_held_q;
    assign aw_hs     = awvalid_i && awready_o;
    assign w_hs      = wvalid_i && wready_o;
    assign aw_have   = aw_held_q || aw_hs;
    assign w_have    = w_held_q || w_hs;

    always_comb begin
        state_d = state_q;
        case (state_q)
            W_IDLE, W_COLLECT: begin
                if (aw_have && w_have) begin
                    state_d = W_WRITE;
                end else if (aw_have || w_have) begin
                    state_d = W_COLLECT;
                end
            end
            W_WRITE: state_d = W_RESP;
            W_RESP: begin
                if (bready_i) begin
                    state_d = W_IDLE;
                end
            end
            default: state_d = W_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state_q   <= W_IDLE;
            aw_held_q <= 1'b0;
            w_held_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            // flags drop once the write is issued
            if (state_q == W_WRITE) begin
                aw_held_q <= 1'b0;
                w_held_q  <= 1'b0;
            end else begin
                aw_held_q <= aw_have;
                w_held_q  <= w_have;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (aw_hs) begin
            wr_idx_o <= awaddr_i[AXIL_ADDR_W-1:2];
        end
        if (w_hs) begin
            wr_data_o <= wdata_i;
            wr_strb_o <= wstrb_i;
        end
    end

    assign wr_en_o  = (state_q == W_WRITE);
    assign bvalid_o = (state_q == W_RESP);
    assign bresp_o  = RESP_OKAY;

    // write pulse only with both beats held and no response pending
    a_wr_no_overlap: assert property (
        @(posedge clk) disable iff (!reset_n)
        wr_en_o |-> aw_held_q && w_held_q && !bvalid_o
    ) else $error("write pulse without both beats held or during a pending response");

endmodule

`default_nettype wire

// ==== design/axil_read_port.sv ====
/* AXI-Lite read channel slave
   issues one register read per address beat and holds the returned word */
`timescale 1ns/1ps
`default_nettype none

module axil_read_port
    import gen_cfg_pkg::*;
(
    input  logic       clk,
    input  logic       reset_n,
    input  addr_t      araddr_i,
    input  logic       arvalid_i,
    output logic       arready_o,
    output data_t      rdata_o,
    output logic [1:0] rresp_o,
    output logic       rvalid_o,
    input  logic       rready_i,
    input  data_t      rd_data_i,
    output logic       rd_en_o,
    output reg_idx_t   rd_idx_o
);

    rd_state_t state_q;
    logic      fresh_q;
    data_t     rdata_q;
    logic      ar_hs;

    assign arready_o = (state_q == R_IDLE);
    assign ar_hs     = arvalid_i && arready_o;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state_q <= R_IDLE;
            fresh_q <= 1'b0;
        end else begin
            fresh_q <= (state_q == R_FETCH);
            case (state_q)
                R_IDLE: begin
                    if (ar_hs) begin
                        state_q <= R_FETCH;
                    end
                end
                R_FETCH: state_q <= R_RESP;
                R_RESP: begin
                    if (rready_i) begin
                        state_q <= R_IDLE;
                    end
                end
                default: state_q <= R_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (ar_hs) begin
            rd_idx_o <= araddr_i[AXIL_ADDR_W-1:2];
        end
        // bank word arrives in the first response cycle
        if (fresh_q) begin
            rdata_q <= rd_data_i;
        end
    end

    assign rd_en_o  = (state_q == R_FETCH);
    assign rvalid_o = (state_q == R_RESP);
    assign rdata_o  = fresh_q ? rd_data_i : rdata_q;
    assign rresp_o  = RESP_OKAY;

    a_rdata_held: assert property (
        @(posedge clk) disable iff (!reset_n)
        rvalid_o && !rready_i |=> rvalid_o && $stable(rdata_o)
    ) else $error("read data changed while waiting for rready");

endmodule

`default_nettype wire

// ==== design/gen_cfg_regs.sv ====
/* generator configuration register bank
   byte-strobed writes, start/stop pulses, registered readback and start checks */
`timescale 1ns/1ps
`default_nettype none

module gen_cfg_regs
    import gen_cfg_pkg::*;
(
    input  logic     clk,
    input  logic     reset_n,
    input  logic     wr_en_i,
    input  reg_idx_t wr_idx_i,
    input  data_t    wr_data_i,
    input  strb_t    wr_strb_i,
    input  logic     rd_en_i,
    input  reg_idx_t rd_idx_i,
    output data_t    rd_data_o,
    output logic     start_o,
    output logic     stop_o,
    output logic     auto_length_o,
    output logic     auto_channel_o,
    output logic     auto_pause_o,
    output logic     use_limit_o,
    output len_t     fixed_length_o,
    output len_t     min_length_o,
    output len_t     max_length_o,
    output chan_t    fixed_channel_o,
    output chan_t    min_channel_o,
    output chan_t    max_channel_o,
    output pause_t   fixed_pause_o,
    output pause_t   min_pause_o,
    output pause_t   max_pause_o,
    output count_t   cnt_packet_o
);

    // only the mode bits are stored, start and stop are pulses
    data_t ctrl_q;
    data_t cfg_q [REG_FIXED_LEN:REG_CNT_PACKET];
    logic  start_q;
    logic  stop_q;

    function automatic logic is_len_idx(reg_idx_t idx);
        return (idx >= REG_FIXED_LEN) && (idx <= REG_MAX_LEN);
    endfunction

    function automatic data_t merge_bytes(data_t old_w, data_t new_w, strb_t be);
        data_t res;
        res = old_w;
        for (int b = 0; b < AXIL_STRB_W; b++) begin
            if (be[b]) begin
                res[8*b +: 8] = new_w[8*b +: 8];
            end
        end
        return res;
    endfunction

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            ctrl_q  <= '0;
            start_q <= 1'b0;
            stop_q  <= 1'b0;
            for (int i = REG_FIXED_LEN; i <= REG_CNT_PACKET; i++) begin
                cfg_q[i] <= '0;
            end
        end else begin
            start_q <= 1'b0;
            stop_q  <= 1'b0;
            if (wr_en_i) begin
                if (wr_idx_i == REG_CONTROL) begin
                    if (wr_strb_i[0]) begin
                        start_q <= wr_data_i[CTRL_START];
                        stop_q  <= wr_data_i[CTRL_STOP];
                        ctrl_q[CTRL_USE_LIMIT:CTRL_AUTO_LEN] <=
                            wr_data_i[CTRL_USE_LIMIT:CTRL_AUTO_LEN];
                    end
                end else if (is_len_idx(wr_idx_i)) begin
                    cfg_q[wr_idx_i] <= merge_bytes(cfg_q[wr_idx_i], wr_data_i,
                                                   wr_strb_i & LEN_STRB_MASK);
                end else if (wr_idx_i <= REG_CNT_PACKET) begin
                    cfg_q[wr_idx_i] <= merge_bytes(cfg_q[wr_idx_i], wr_data_i, wr_strb_i);
                end
            end
        end
    end

    // readback, one cycle after rd_en
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rd_data_o <= '0;
        end else if (rd_en_i) begin
            if (rd_idx_i == REG_CONTROL) begin
                rd_data_o <= ctrl_q;
            end else if (is_len_idx(rd_idx_i)) begin
                rd_data_o <= {{(AXIL_DATA_W-LEN_W){1'b0}}, cfg_q[rd_idx_i][LEN_W-1:0]};
            end else if (rd_idx_i <= REG_CNT_PACKET) begin
                rd_data_o <= cfg_q[rd_idx_i];
            end else begin
                rd_data_o <= '0;
            end
        end
    end

    assign start_o        = start_q;
    assign stop_o         = stop_q;
    assign auto_length_o  = ctrl_q[CTRL_AUTO_LEN];
    assign auto_channel_o = ctrl_q[CTRL_AUTO_CHAN];
    assign auto_pause_o   = ctrl_q[CTRL_AUTO_PAUSE];
    assign use_limit_o    = ctrl_q[CTRL_USE_LIMIT];

    assign fixed_length_o = cfg_q[REG_FIXED_LEN][LEN_W-1:0];
    assign min_length_o   = cfg_q[REG_MIN_LEN][LEN_W-1:0];
    assign max_length_o   = cfg_q[REG_MAX_LEN][LEN_W-1:0];

    // generator sees only the channel ID bits
    assign fixed_channel_o = cfg_q[REG_FIXED_CHAN][CHAN_W-1:0];
    assign min_channel_o   = cfg_q[REG_MIN_CHAN][CHAN_W-1:0];
    assign max_channel_o   = cfg_q[REG_MAX_CHAN][CHAN_W-1:0];

    assign fixed_pause_o = cfg_q[REG_FIXED_PAUSE];
    assign min_pause_o   = cfg_q[REG_MIN_PAUSE];
    assign max_pause_o   = cfg_q[REG_MAX_PAUSE];
    assign cnt_packet_o  = cfg_q[REG_CNT_PACKET];

    // settings must be sane when the generator is started
    a_start_known: assert property (
        @(posedge clk) disable iff (!reset_n)
        start_o |-> !$isunknown({ctrl_q, fixed_length_o, min_length_o, max_length_o,
                                 fixed_channel_o, min_channel_o, max_channel_o,
                                 fixed_pause_o, min_pause_o, max_pause_o, cnt_packet_o})
    ) else $error("unknown configuration at start");

    a_start_len_nonzero: assert property (
        @(posedge clk) disable iff (!reset_n)
        start_o |-> (auto_length_o ? (min_length_o != '0 && max_length_o != '0)
                                   : (fixed_length_o != '0))
    ) else $error("zero length at start");

    a_start_minmax: assert property (
        @(posedge clk) disable iff (!reset_n)
        start_o |-> (max_length_o > min_length_o) && (max_channel_o > min_channel_o)
                    && (max_pause_o > min_pause_o)
    ) else $error("min not below max at start");

    a_start_count: assert property (
        @(posedge clk) disable iff (!reset_n)
        start_o && use_limit_o |-> cnt_packet_o != '0
    ) else $error("zero packet count with limit enabled");

endmodule

`default_nettype wire

// ==== design/genaxis_cfg_top.sv ====
/* AXI-stream generator configuration block
   AXI-Lite write and read ports sharing one register bank */
`timescale 1ns/1ps
`default_nettype none

module genaxis_cfg_top
    import gen_cfg_pkg::*;
(
    input  logic       clk,
    input  logic       reset_n,
    // write address, data and response
    input  addr_t      s_axil_awaddr_i,
    input  logic       s_axil_awvalid_i,
    output logic       s_axil_awready_o,
    input  data_t      s_axil_wdata_i,
    input  strb_t      s_axil_wstrb_i,
    input  logic       s_axil_wvalid_i,
    output logic       s_axil_wready_o,
    output logic [1:0] s_axil_bresp_o,
    output logic       s_axil_bvalid_o,
    input  logic       s_axil_bready_i,
    // read address and data
    input  addr_t      s_axil_araddr_i,
    input  logic       s_axil_arvalid_i,
    output logic       s_axil_arready_o,
    output data_t      s_axil_rdata_o,
    output logic [1:0] s_axil_rresp_o,
    output logic       s_axil_rvalid_o,
    input  logic       s_axil_rready_i,
    // generator settings
    output logic       start_o,
    output logic       stop_o,
    output logic       auto_length_o,
    output logic       auto_channel_o,
    output logic       auto_pause_o,
    output logic       use_limit_o,
    output len_t       fixed_length_o,
    output len_t       min_length_o,
    output len_t       max_length_o,
    output chan_t      fixed_channel_o,
    output chan_t      min_channel_o,
    output chan_t      max_channel_o,
    output pause_t     fixed_pause_o,
    output pause_t     min_pause_o,
    output pause_t     max_pause_o,
    output count_t     cnt_packet_o
);

    logic     wr_en;
    reg_idx_t wr_idx;
    data_t    wr_data;
    strb_t    wr_strb;
    logic     rd_en;
    reg_idx_t rd_idx;
    data_t    rd_data;

    axil_write_port u_write_port (
        .clk       (clk),
        .reset_n   (reset_n),
        .awaddr_i  (s_axil_awaddr_i),
        .awvalid_i (s_axil_awvalid_i),
        .awready_o (s_axil_awready_o),
        .wdata_i   (s_axil_wdata_i),
        .wstrb_i   (s_axil_wstrb_i),
        .wvalid_i  (s_axil_wvalid_i),
        .wready_o  (s_axil_wready_o),
        .bresp_o   (s_axil_bresp_o),
        .bvalid_o  (s_axil_bvalid_o),
        .bready_i  (s_axil_bready_i),
        .wr_en_o   (wr_en),
        .wr_idx_o  (wr_idx),
        .wr_data_o (wr_data),
        .wr_strb_o (wr_strb)
    );

    axil_read_port u_read_port (
        .clk       (clk),
        .reset_n   (reset_n),
        .araddr_i  (s_axil_araddr_i),
        .arvalid_i (s_axil_arvalid_i),
        .arready_o (s_axil_arready_o),
        .rdata_o   (s_axil_rdata_o),
        .rresp_o   (s_axil_rresp_o),
        .rvalid_o  (s_axil_rvalid_o),
        .rready_i  (s_axil_rready_i),
        .rd_data_i (rd_data),
        .rd_en_o   (rd_en),
        .rd_idx_o  (rd_idx)
    );

    gen_cfg_regs u_regs (
        .clk             (clk),
        .reset_n         (reset_n),
        .wr_en_i         (wr_en),
        .wr_idx_i        (wr_idx),
        .wr_data_i       (wr_data),
        .wr_strb_i       (wr_strb),
        .rd_en_i         (rd_en),
        .rd_idx_i        (rd_idx),
        .rd_data_o       (rd_data),
        .start_o         (start_o),
        .stop_o          (stop_o),
        .auto_length_o   (auto_length_o),
        .auto_channel_o  (auto_channel_o),
        .auto_pause_o    (auto_pause_o),
        .use_limit_o     (use_limit_o),
        .fixed_length_o  (fixed_length_o),
        .min_length_o    (min_length_o),
        .max_length_o    (max_length_o),
        .fixed_channel_o (fixed_channel_o),
        .min_channel_o   (min_channel_o),
        .max_channel_o   (max_channel_o),
        .fixed_pause_o   (fixed_pause_o),
        .min_pause_o     (min_pause_o),
        .max_pause_o     (max_pause_o),
        .cnt_packet_o    (cnt_packet_o)
    );

endmodule

`default_nettype wire

// ==== bench/tb_clock.sv ====
/* testbench clock source
   free-running clock, 8 ns period */
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int HALF_PERIOD_NS = 4
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
    end

    always begin
        #(HALF_PERIOD_NS);
        clk_o = ~clk_o;
    end

endmodule

`default_nettype wire

// ==== bench/genaxis_cfg_tb.sv ====
/* testbench for the generator configuration block
   directed AXI-Lite tests of register map, strobes, control pulses and handshakes */
`timescale 1ns/1ps
`default_nettype none

module genaxis_cfg_tb
    import gen_cfg_pkg::*;
();

    localparam int    NUM_TESTS  = 5;
    localparam int    TIMEOUT_NS = NUM_TESTS * 2000;
    localparam data_t LEN_MASK   = 32'h0000_ffff;
    localparam data_t CHAN_MASK  = (32'd1 << CHAN_W) - 32'd1;

    logic       clk;
    logic       reset_n;
    addr_t      awaddr;
    logic       awvalid;
    logic       awready;
    data_t      wdata;
    strb_t      wstrb;
    logic       wvalid;
    logic       wready;
    logic [1:0] bresp;
    logic       bvalid;
    logic       bready;
    addr_t      araddr;
    logic       arvalid;
    logic       arready;
    data_t      rdata;
    logic [1:0] rresp;
    logic       rvalid;
    logic       rready;

    logic   start_o;
    logic   stop_o;
    logic   auto_length_o;
    logic   auto_channel_o;
    logic   auto_pause_o;
    logic   use_limit_o;
    len_t   fixed_length_o;
    len_t   min_length_o;
    len_t   max_length_o;
    chan_t  fixed_channel_o;
    chan_t  min_channel_o;
    chan_t  max_channel_o;
    pause_t fixed_pause_o;
    pause_t min_pause_o;
    pause_t max_pause_o;
    count_t cnt_packet_o;

    integer seed       = 19;
    int     err_cnt    = 0;
    int     pass_cnt   = 0;
    int     test_errs  = 0;
    int     start_seen = 0;
    int     stop_seen  = 0;
    string  cur_test   = "";

    tb_clock u_clock (
        .clk_o (clk)
    );

    genaxis_cfg_top DUT (
        .clk              (clk),
        .reset_n          (reset_n),
        .s_axil_awaddr_i  (awaddr),
        .s_axil_awvalid_i (awvalid),
        .s_axil_awready_o (awready),
        .s_axil_wdata_i   (wdata),
        .s_axil_wstrb_i   (wstrb),
        .s_axil_wvalid_i  (wvalid),
        .s_axil_wready_o  (wready),
        .s_axil_bresp_o   (bresp),
        .s_axil_bvalid_o  (bvalid),
        .s_axil_bready_i  (bready),
        .s_axil_araddr_i  (araddr),
        .s_axil_arvalid_i (arvalid),
        .s_axil_arready_o (arready),
        .s_axil_rdata_o   (rdata),
        .s_axil_rresp_o   (rresp),
        .s_axil_rvalid_o  (rvalid),
        .s_axil_rready_i  (rready),
        .start_o          (start_o),
        .stop_o           (stop_o),
        .auto_length_o    (auto_length_o),
        .auto_channel_o   (auto_channel_o),
        .auto_pause_o     (auto_pause_o),
        .use_limit_o      (use_limit_o),
        .fixed_length_o   (fixed_length_o),
        .min_length_o     (min_length_o),
        .max_length_o     (max_length_o),
        .fixed_channel_o  (fixed_channel_o),
        .min_channel_o    (min_channel_o),
        .max_channel_o    (max_channel_o),
        .fixed_pause_o    (fixed_pause_o),
        .min_pause_o      (min_pause_o),
        .max_pause_o      (max_pause_o),
        .cnt_packet_o     (cnt_packet_o)
    );

    // count cycles with a pulse high, sampled mid-cycle
    always @(negedge clk) begin
        if (start_o) begin
            start_seen = start_seen + 1;
        end
        if (stop_o) begin
            stop_seen = stop_seen + 1;
        end
    end

    task automatic check(input string name, input data_t expected, input data_t actual);
        if (expected !== actual) begin
            err_cnt = err_cnt + 1;
            $display("** Error [%s] %s: expected %h, actual %h", cur_test, name,
                     expected, actual);
        end else begin
            pass_cnt = pass_cnt + 1;
        end
    endtask

    task automatic report_failure(input string what);
        err_cnt = err_cnt + 1;
        $display("** Failure [%s] %s", cur_test, what);
    endtask

    task automatic open_test(input string name);
        cur_test  = name;
        test_errs = err_cnt;
    endtask

    task automatic close_test();
        $display("test %s finished with %0d errors", cur_test, err_cnt - test_errs);
    endtask

    function automatic addr_t idx_addr(input int idx);
        return addr_t'(idx << 2);
    endfunction

    // generator output belonging to a register index, zero extended
    function automatic data_t generator_output(input int idx);
        case (idx)
            REG_FIXED_LEN:   return data_t'(fixed_length_o);
            REG_MIN_LEN:     return data_t'(min_length_o);
            REG_MAX_LEN:     return data_t'(max_length_o);
            REG_FIXED_CHAN:  return data_t'(fixed_channel_o);
            REG_MIN_CHAN:    return data_t'(min_channel_o);
            REG_MAX_CHAN:    return data_t'(max_channel_o);
            REG_FIXED_PAUSE: return fixed_pause_o;
            REG_MIN_PAUSE:   return min_pause_o;
            REG_MAX_PAUSE:   return max_pause_o;
            REG_CNT_PACKET:  return cnt_packet_o;
            default:         return '0;
        endcase
    endfunction

    // order 1 sends data first, order 2 the address first, bwait delays bready
    task automatic axil_write(input addr_t addr, input data_t data, input strb_t strb,
                              input int order, input int bwait);
        logic aw_done;
        logic w_done;
        logic aw_fire;
        logic w_fire;
        aw_done = 1'b0;
        w_done  = 1'b0;
        awaddr  = addr;
        wdata   = data;
        wstrb   = strb;
        awvalid = (order != 1);
        wvalid  = (order != 2);
        while (!(aw_done && w_done)) begin
            aw_fire = awvalid && awready;
            w_fire  = wvalid && wready;
            @(negedge clk);
            if (aw_fire) begin
                awvalid = 1'b0;
                aw_done = 1'b1;
            end
            if (w_fire) begin
                wvalid = 1'b0;
                w_done = 1'b1;
            end
            // second channel follows once the first is taken
            if (aw_done && !w_done) begin
                wvalid = 1'b1;
            end
            if (w_done && !aw_done) begin
                awvalid = 1'b1;
            end
        end
        bready = (bwait == 0);
        while (!bvalid) begin
            @(negedge clk);
        end
        for (int i = 0; i < bwait; i++) begin
            check("ready during back-pressure", 32'd0, data_t'({awready, wready}));
            @(negedge clk);
            if (!bvalid) begin
                report_failure("bvalid dropped before bready was given");
            end
        end
        bready = 1'b1;
        check("bresp", data_t'(RESP_OKAY), data_t'(bresp));
        @(negedge clk);
        bready = 1'b0;
    endtask

    // rwait holds rready low for that many cycles after rvalid
    task automatic axil_read(input addr_t addr, output data_t data, input int rwait);
        data_t held;
        araddr  = addr;
        arvalid = 1'b1;
        while (!arready) begin
            @(negedge clk);
        end
        @(negedge clk);
        arvalid = 1'b0;
        rready  = (rwait == 0);
        while (!rvalid) begin
            @(negedge clk);
        end
        held = rdata;
        for (int i = 0; i < rwait; i++) begin
            @(negedge clk);
            if (!rvalid) begin
                report_failure("rvalid dropped before rready was given");
            end
            check("rdata held", held, rdata);
        end
        rready = 1'b1;
        check("rresp", data_t'(RESP_OKAY), data_t'(rresp));
        data = rdata;
        @(negedge clk);
        rready = 1'b0;
    endtask

    task automatic test_reset_values();
        data_t rd;
        open_test("reset_values");
        check("ready after reset", 32'h7, data_t'({awready, wready, arready}));
        check("valid after reset", 32'h0, data_t'({bvalid, rvalid}));
        check("pulses after reset", 32'h0, data_t'({start_o, stop_o}));
        for (int i = 0; i <= 10; i++) begin
            axil_read(idx_addr(i), rd, 0);
            check($sformatf("reg %0d", i), 32'h0, rd);
        end
        axil_read(idx_addr(12), rd, 0);
        check("unmapped reg 12", 32'h0, rd);
        close_test();
    endtask

    task automatic test_write_readback();
        data_t words [1:10];
        data_t rd;
        data_t exp_rd;
        data_t exp_out;
        open_test("write_readback");
        for (int i = 1; i <= 10; i++) begin
            words[i] = $random(seed);
            axil_write(idx_addr(i), words[i], 4'hf, 0, 0);
        end
        for (int i = 1; i <= 10; i++) begin
            // lengths keep 16 bits, channel outputs keep CHAN_W bits
            exp_rd  = (i <= 3) ? (words[i] & LEN_MASK) : words[i];
            exp_out = exp_rd;
            if (i >= 4 && i <= 6) begin
                exp_out = words[i] & CHAN_MASK;
            end
            axil_read(idx_addr(i), rd, 0);
            check($sformatf("readback %0d", i), exp_rd, rd);
            check($sformatf("output %0d", i), exp_out, generator_output(i));
        end
        close_test();
    endtask

    task automatic test_byte_strobes();
        data_t rd;
        open_test("byte_strobes");
        axil_write(idx_addr(REG_MIN_PAUSE), 32'h1122_3344, 4'hf, 0, 0);
        axil_write(idx_addr(REG_MIN_PAUSE), 32'haabb_ccdd, 4'b0100, 0, 0);
        axil_read(idx_addr(REG_MIN_PAUSE), rd, 0);
        check("pause byte 2", 32'h11bb_3344, rd);
        check("min_pause_o", 32'h11bb_3344, min_pause_o);
        axil_write(idx_addr(REG_MAX_CHAN), 32'h5566_7788, 4'hf, 0, 0);
        axil_write(idx_addr(REG_MAX_CHAN), 32'h99aa_bbcc, 4'b0001, 0, 0);
        axil_read(idx_addr(REG_MAX_CHAN), rd, 0);
        check("channel byte 0", 32'h5566_77cc, rd);
        check("max_channel_o", 32'h5566_77cc & CHAN_MASK, data_t'(max_channel_o));
        // upper lanes do not exist on a length register
        axil_write(idx_addr(REG_FIXED_LEN), 32'h0000_1234, 4'hf, 0, 0);
        axil_write(idx_addr(REG_FIXED_LEN), 32'hffff_ffff, 4'b1100, 0, 0);
        axil_read(idx_addr(REG_FIXED_LEN), rd, 0);
        check("length upper strobes", 32'h0000_1234, rd);
        close_test();
    endtask

    task automatic test_control_pulses();
        data_t rd;
        data_t ctrl;
        int    n_start;
        int    n_stop;
        open_test("control_pulses");
        axil_write(idx_addr(REG_FIXED_LEN), 32'd64, 4'hf, 0, 0);
        axil_write(idx_addr(REG_MIN_LEN), 32'd16, 4'hf, 0, 0);
        axil_write(idx_addr(REG_MAX_LEN), 32'd256, 4'hf, 0, 0);
        axil_write(idx_addr(REG_FIXED_CHAN), 32'd3, 4'hf, 0, 0);
        axil_write(idx_addr(REG_MIN_CHAN), 32'd1, 4'hf, 0, 0);
        axil_write(idx_addr(REG_MAX_CHAN), 32'd7, 4'hf, 0, 0);
        axil_write(idx_addr(REG_FIXED_PAUSE), 32'd10, 4'hf, 0, 0);
        axil_write(idx_addr(REG_MIN_PAUSE), 32'd2, 4'hf, 0, 0);
        axil_write(idx_addr(REG_MAX_PAUSE), 32'd20, 4'hf, 0, 0);
        axil_write(idx_addr(REG_CNT_PACKET), 32'd100, 4'hf, 0, 0);

        ctrl                 = '0;
        ctrl[CTRL_START]     = 1'b1;
        ctrl[CTRL_AUTO_LEN]  = 1'b1;
        ctrl[CTRL_USE_LIMIT] = 1'b1;
        n_start = start_seen;
        n_stop  = stop_seen;
        axil_write(idx_addr(REG_CONTROL), ctrl, 4'hf, 0, 0);
        repeat (3) @(negedge clk);
        check("start pulse cycles", 32'd1, data_t'(start_seen - n_start));
        check("stop during start", 32'd0, data_t'(stop_seen - n_stop));
        check("modes after start", 32'b1001,
              data_t'({use_limit_o, auto_pause_o, auto_channel_o, auto_length_o}));
        axil_read(idx_addr(REG_CONTROL), rd, 0);
        check("control after start", ctrl & ~32'h3, rd);

        ctrl                  = '0;
        ctrl[CTRL_STOP]       = 1'b1;
        ctrl[CTRL_AUTO_CHAN]  = 1'b1;
        ctrl[CTRL_AUTO_PAUSE] = 1'b1;
        n_start = start_seen;
        n_stop  = stop_seen;
        axil_write(idx_addr(REG_CONTROL), ctrl, 4'hf, 0, 0);
        repeat (3) @(negedge clk);
        check("stop pulse cycles", 32'd1, data_t'(stop_seen - n_stop));
        check("start during stop", 32'd0, data_t'(start_seen - n_start));
        check("modes after stop", 32'b0110,
              data_t'({use_limit_o, auto_pause_o, auto_channel_o, auto_length_o}));
        axil_read(idx_addr(REG_CONTROL), rd, 0);
        check("control after stop", ctrl & ~32'h3, rd);
        close_test();
    endtask

    task automatic test_handshake_order();
        data_t rd;
        open_test("handshake_order");
        axil_write(idx_addr(REG_FIXED_PAUSE), 32'hcafe_0001, 4'hf, 1, 0);
        axil_write(idx_addr(REG_MIN_LEN), 32'h0000_4321, 4'hf, 2, 0);
        axil_write(idx_addr(REG_CNT_PACKET), 32'h0bad_f00d, 4'hf, 0, 5);
        axil_read(idx_addr(REG_FIXED_PAUSE), rd, 4);
        check("data before address", 32'hcafe_0001, rd);
        axil_read(idx_addr(REG_MIN_LEN), rd, 0);
        check("address before data", 32'h0000_4321, rd);
        axil_read(idx_addr(REG_CNT_PACKET), rd, 0);
        check("late bready", 32'h0bad_f00d, rd);
        close_test();
    endtask

    initial begin
        #(TIMEOUT_NS);
        $display("watchdog expired after %0d ns, tests did not complete", TIMEOUT_NS);
        $display("Test failures found");
        $finish;
    end

    initial begin
        reset_n = 1'b0;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;
        @(negedge clk);

        test_reset_values();
        test_write_readback();
        test_byte_strobes();
        test_control_pulses();
        test_handshake_order();

        $display("checks passed: %0d, checks failed: %0d", pass_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
design/gen_cfg_pkg.sv
design/axil_write_port.sv
design/axil_read_port.sv
design/gen_cfg_regs.sv
design/genaxis_cfg_top.sv
bench/tb_clock.sv
bench/genaxis_cfg_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing -Wall
TOP        := genaxis_cfg_tb
FILELIST   := all.f
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_TEXT  := All tests passed!

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "simulation failed, see $(LOG)" && exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
